/* Makefile */
TOP := correlator_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* common/corr_defs.svh */
// sizes may change together, but at least two inputs and two lags are needed, and at most 16 lags.
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// number of digitized input channels.
`define CORR_NUM_INPUTS 4

// signed sample width in bits.
`define CORR_SAMPLE_WIDTH 8

// lags per baseline, covering lag 0 to CORR_NUM_LAGS-1.
`define CORR_NUM_LAGS 3

// signed accumulator width; sums clamp at its extremes.
`define CORR_ACC_WIDTH 18

// every unordered pair of inputs forms one baseline.
`define CORR_NUM_BASELINES (`CORR_NUM_INPUTS * (`CORR_NUM_INPUTS - 1) / 2)

`define CORR_NUM_CELLS (`CORR_NUM_BASELINES * `CORR_NUM_LAGS)

`endif

/* common/corr_pkg.sv */
// shared correlator types; the baseline field holds up to 256 baselines and the lag field 16 lags.
`include "corr_defs.svh"

package corr_pkg;

	typedef logic signed [`CORR_SAMPLE_WIDTH-1:0] sample_t;

	// one sample per input, input 0 in the low bits.
	typedef struct packed {
		sample_t [`CORR_NUM_INPUTS-1:0] smp;
	} sample_vec_t;

	// hist[k] holds the vector accepted k+1 vectors before cur.
	typedef struct packed {
		sample_vec_t                        cur;
		sample_vec_t [`CORR_NUM_LAGS-2:0]   hist;
		logic                               strobe;
		logic                               last;
	} tap_t;

	typedef struct packed {
		logic [7:0]                         baseline;
		logic [3:0]                         lag;
		logic signed [`CORR_ACC_WIDTH-1:0]  sum;
		logic                               overflow;
	} corr_result_t;

	typedef enum logic {
		rd_idle,
		rd_stream
	} readout_state_t;

endpackage

/* design/correlation_readout.sv */
// one snapshot at a time; words leave in cell order, baseline first, then lag.
`include "corr_defs.svh"

module correlation_readout import corr_pkg::*; (
	input  logic                                     pllclk,
	input  logic                                     reset,
	input  corr_result_t [`CORR_NUM_CELLS-1:0]       results,
	input  logic [`CORR_NUM_CELLS-1:0]               dump,
	output logic                                     snap_ready,
	output logic                                     out_valid,
	input  logic                                     out_ready,
	output corr_result_t                             out_data
);

	localparam int num_cells = `CORR_NUM_CELLS;
	localparam int idx_w = (num_cells > 1) ? $clog2(num_cells) : 1;

	readout_state_t                     state;
	corr_result_t [num_cells-1:0]       snap;
	logic [idx_w-1:0]                   idx;
	logic                               last_word;
	logic                               capture;

	assign last_word = (idx == idx_w'(num_cells - 1));
	assign out_valid = (state == rd_stream);
	assign out_data = snap[idx];
	assign snap_ready = (state == rd_idle) || (last_word && out_ready);

	// all cells dump together, so cell 0 stands for the whole array.
	assign capture = dump[0] && snap_ready;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= rd_idle;
			idx <= '0;
		end else begin
			case (state)
				rd_idle: begin
					if (capture) begin
						state <= rd_stream;
						idx <= '0;
					end
				end
				rd_stream: begin
					if (out_ready) begin
						if (!last_word) begin
							idx <= idx + 1'b1;
						end else if (capture) begin
							idx <= '0;
						end else begin
							state <= rd_idle;
						end
					end
				end
				default: begin
					state <= rd_idle;
				end
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		if (capture) begin
			snap <= results;
		end
	end

	a_dump_aligned: assert property (@(posedge pllclk) disable iff (!reset)
		(dump == '0) || (dump == '1))
		else $error("cells dumped out of step");

	a_dump_taken: assert property (@(posedge pllclk) disable iff (!reset)
		dump[0] |-> snap_ready)
		else $error("snapshot arrived while readout busy");

	a_out_stable: assert property (@(posedge pllclk) disable iff (!reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
		else $error("output word changed while stalled");

endmodule

/* design/correlator_top.sv */
// all ports run on pllclk; chan_enable is applied to each product as it is formed.
`include "corr_defs.svh"

module correlator_top import corr_pkg::*; (
	input  logic                        pllclk,
	input  logic                        reset,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  sample_vec_t                 in_data,
	input  logic [7:0]                  integ_len,
	input  logic [`CORR_NUM_INPUTS-1:0] chan_enable,
	output logic                        out_valid,
	input  logic                        out_ready,
	output corr_result_t                out_data
);

	localparam int num_in = `CORR_NUM_INPUTS;
	localparam int num_lags = `CORR_NUM_LAGS;

	tap_t                                   tap;
	corr_result_t [`CORR_NUM_CELLS-1:0]     results;
	logic [`CORR_NUM_CELLS-1:0]             dump;
	logic                                   snap_ready;

	sample_delay u_delay (
		.pllclk     (pllclk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_data    (in_data),
		.integ_len  (integ_len),
		.snap_ready (snap_ready),
		.tap        (tap)
	);

	// baselines are numbered (0,1), (0,2), ... so pair (a,b) lands at a row offset plus b-a-1.
	for (genvar a = 0; a < num_in - 1; a++) begin : g_a
		for (genvar b = a + 1; b < num_in; b++) begin : g_b
			localparam int bl = a * (2 * num_in - a - 1) / 2 + (b - a - 1);
			for (genvar l = 0; l < num_lags; l++) begin : g_lag
				lag_accumulator #(
					.baseline_idx (bl),
					.in_a         (a),
					.in_b         (b),
					.lag          (l)
				) u_cell (
					.pllclk      (pllclk),
					.reset       (reset),
					.tap         (tap),
					.chan_enable (chan_enable),
					.result      (results[bl * num_lags + l]),
					.dump        (dump[bl * num_lags + l])
				);
			end
		end
	end

	correlation_readout u_readout (
		.pllclk     (pllclk),
		.reset      (reset),
		.results    (results),
		.dump       (dump),
		.snap_ready (snap_ready),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data)
	);

endmodule

/* design/lag_accumulator.sv */
// one baseline and lag; a product is added two cycles after its vector is accepted.
`include "corr_defs.svh"

module lag_accumulator import corr_pkg::*; #(
	parameter int baseline_idx = 0,
	parameter int in_a = 0,
	parameter int in_b = 1,
	parameter int lag = 0
) (
	input  logic                        pllclk,
	input  logic                        reset,
	input  tap_t                        tap,
	input  logic [`CORR_NUM_INPUTS-1:0] chan_enable,
	output corr_result_t                result,
	output logic                        dump
);

	localparam int acc_w = `CORR_ACC_WIDTH;
	localparam int prod_w = 2 * `CORR_SAMPLE_WIDTH;
	localparam int sum_w = ((acc_w > prod_w) ? acc_w : prod_w) + 1;
	localparam logic signed [sum_w-1:0] acc_max = sum_w'(2 ** (acc_w - 1) - 1);
	localparam logic signed [sum_w-1:0] acc_min = -acc_max - 1;

	sample_t                   samp_a;
	sample_t                   samp_b;
	logic signed [prod_w-1:0]  prod_q;
	logic                      add_q;
	logic                      last_q;
	logic signed [acc_w-1:0]   acc;
	logic                      ovf;
	logic signed [sum_w-1:0]   sum_wide;
	logic signed [acc_w-1:0]   acc_next;
	logic                      ovf_next;
	logic signed [acc_w-1:0]   sum_q;
	logic                      ovf_q;

	assign samp_a = tap.cur.smp[in_a];
	if (lag == 0) begin : g_lag0
		assign samp_b = tap.cur.smp[in_b];
	end else begin : g_lagn
		assign samp_b = tap.hist[lag - 1].smp[in_b];
	end

	always_ff @(posedge pllclk) begin
		if (chan_enable[in_a] && chan_enable[in_b]) begin
			prod_q <= samp_a * samp_b;
		end else begin
			prod_q <= '0;
		end
		if (!reset) begin
			add_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			add_q <= tap.strobe;
			last_q <= tap.last;
		end
	end

	always_comb begin
		sum_wide = acc + prod_q;
		acc_next = sum_wide[acc_w-1:0];
		ovf_next = ovf;
		if (sum_wide > acc_max) begin
			acc_next = acc_max[acc_w-1:0];
			ovf_next = 1'b1;
		end else if (sum_wide < acc_min) begin
			acc_next = acc_min[acc_w-1:0];
			ovf_next = 1'b1;
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			acc <= '0;
			ovf <= 1'b0;
			dump <= 1'b0;
		end else begin
			dump <= add_q && last_q;
			if (add_q) begin
				acc <= last_q ? '0 : acc_next;
				ovf <= last_q ? 1'b0 : ovf_next;
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (add_q && last_q) begin
			sum_q <= acc_next;
			ovf_q <= ovf_next;
		end
	end

	assign result = '{baseline: 8'(baseline_idx), lag: 4'(lag), sum: sum_q, overflow: ovf_q};

	// integrations are at least one vector long, and the delay stage spaces them out.
	a_dump_single: assert property (@(posedge pllclk) disable iff (!reset) dump |=> !dump)
		else $error("dump held for two cycles");

endmodule

/* design/sample_delay.sv */
// integ_len is taken on the first vector of each integration; history survives between integrations.
`include "corr_defs.svh"

module sample_delay import corr_pkg::*; (
	input  logic        pllclk,
	input  logic        reset,
	input  logic        in_valid,
	output logic        in_ready,
	input  sample_vec_t in_data,
	input  logic [7:0]  integ_len,
	input  logic        snap_ready,
	output tap_t        tap
);

	logic [7:0] cnt;
	logic [7:0] len_q;
	logic [7:0] norm_len;
	logic [7:0] eff_len;
	logic [1:0] hold;
	logic       is_last;
	logic       accept;

	// a length of zero runs as a single vector.
	assign norm_len = (integ_len == 8'd0) ? 8'd1 : integ_len;
	assign eff_len = (cnt == 8'd0) ? norm_len : len_q;
	assign is_last = (cnt == eff_len - 8'd1);

	// a dumped snapshot needs three cycles to reach the readout, and snap_ready only
	// reflects it after capture, so another last vector waits out that window.
	assign in_ready = !(is_last && (!snap_ready || hold != 2'd0));
	assign accept = in_valid && in_ready;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			cnt <= 8'd0;
			len_q <= 8'd0;
			hold <= 2'd0;
		end else begin
			if (accept) begin
				if (cnt == 8'd0) begin
					len_q <= norm_len;
				end
				cnt <= is_last ? 8'd0 : cnt + 8'd1;
			end
			if (accept && is_last) begin
				hold <= 2'd3;
			end else if (hold != 2'd0) begin
				hold <= hold - 2'd1;
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			tap <= '0;
		end else begin
			tap.strobe <= accept;
			tap.last <= accept && is_last;
			if (accept) begin
				tap.cur <= in_data;
				tap.hist[0] <= tap.cur;
				for (int k = 1; k < `CORR_NUM_LAGS - 1; k++) begin
					tap.hist[k] <= tap.hist[k - 1];
				end
			end
		end
	end

	// once hold is down to one, the dump of the closing vector sits at the readout,
	// which must be free to take it.
	a_last_needs_snap: assert property (@(posedge pllclk) disable iff (!reset)
		(hold == 2'd1) |-> snap_ready)
		else $error("snapshot reached the readout while it was busy");

endmodule

/* sources.f */
+incdir+common
common/corr_pkg.sv
design/sample_delay.sv
design/lag_accumulator.sv
design/correlation_readout.sv
design/correlator_top.sv
verif/correlator_tb.sv

/* verif/correlator_tb.sv */
// expects the default sizes' 18 cells per integration; chan_enable and integ_len change only when idle.
`include "corr_defs.svh"

module correlator_tb import corr_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int total_vectors = 8 + 15 + 8 + 48 + 12 + 3;
	localparam int total_integ = 2 + 3 + 2 + 3 + 4 + 3;
	localparam int timeout_cycles = 4 * (total_vectors + total_integ * `CORR_NUM_CELLS) + 200;
	localparam int acc_max = (1 << (`CORR_ACC_WIDTH - 1)) - 1;
	localparam int acc_min = -acc_max - 1;

	logic                        pllclk;
	logic                        reset;
	logic                        in_valid;
	logic                        in_ready;
	sample_vec_t                 in_data;
	logic [7:0]                  integ_len;
	logic [`CORR_NUM_INPUTS-1:0] chan_enable;
	logic                        out_valid;
	logic                        out_ready;
	corr_result_t                out_data;

	logic [31:0]     lfsr = 32'hcfb3_1461;
	logic            stall_mode = 1'b0;
	logic            ready_bit = 1'b1;
	sample_vec_t     hist_q[$];
	corr_result_t    exp_q[$];
	corr_result_t    want;
	corr_result_t    held;
	logic            stalled = 1'b0;
	int              integ_cnt = 0;
	int              integ_cur = 1;
	int              n_integ = 0;
	int              n_out = 0;
	int              cycles = 0;
	int              mismatch_count = 0;
	int              other_count = 0;

	correlator_top dut (
		.pllclk      (pllclk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_data     (in_data),
		.integ_len   (integ_len),
		.chan_enable (chan_enable),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_data    (out_data)
	);

	initial begin
		pllclk = 1'b0;
		forever #50 pllclk = ~pllclk;
	end

	// taps 32, 22, 2 and 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_bit()};
		end
		return r;
	endfunction

	// kind 0 is small random, 1 is all most negative, 2 alternates full-scale signs.
	function automatic sample_vec_t make_vector(input int kind);
		sample_vec_t v;
		logic [31:0] r;
		for (int i = 0; i < `CORR_NUM_INPUTS; i++) begin
			if (kind == 0) begin
				r = lfsr_bits(4);
				v.smp[i] = {{(`CORR_SAMPLE_WIDTH - 4){r[3]}}, r[3:0]};
			end else if (kind == 1 || i % 2 == 1) begin
				v.smp[i] = {1'b1, {(`CORR_SAMPLE_WIDTH - 1){1'b0}}};
			end else begin
				v.smp[i] = {1'b0, {(`CORR_SAMPLE_WIDTH - 1){1'b1}}};
			end
		end
		return v;
	endfunction

	// sum of one baseline and lag over an integration, clamped after every add.
	function automatic corr_result_t ref_result(input int bl, input int a, input int b,
			input int lag, input int first, input int len);
		corr_result_t r;
		sample_vec_t  v;
		int           acc;
		int           pa;
		int           pb;
		logic         ovf;
		acc = 0;
		ovf = 1'b0;
		for (int i = first; i < first + len; i++) begin
			v = hist_q[i];
			pa = int'(v.smp[a]);
			pb = 0;
			if (i - lag >= 0) begin
				v = hist_q[i - lag];
				pb = int'(v.smp[b]);
			end
			if (chan_enable[a] && chan_enable[b]) begin
				acc = acc + pa * pb;
			end
			if (acc > acc_max) begin
				acc = acc_max;
				ovf = 1'b1;
			end else if (acc < acc_min) begin
				acc = acc_min;
				ovf = 1'b1;
			end
		end
		r.baseline = 8'(bl);
		r.lag = 4'(lag);
		r.sum = `CORR_ACC_WIDTH'(acc);
		r.overflow = ovf;
		return r;
	endfunction

	task automatic record_vector(input sample_vec_t v);
		int bl;
		hist_q.push_back(v);
		if (integ_cnt == 0) begin
			integ_cur = (integ_len == 8'd0) ? 1 : int'(integ_len);
		end
		integ_cnt++;
		if (integ_cnt == integ_cur) begin
			bl = 0;
			for (int a = 0; a < `CORR_NUM_INPUTS - 1; a++) begin
				for (int b = a + 1; b < `CORR_NUM_INPUTS; b++) begin
					for (int l = 0; l < `CORR_NUM_LAGS; l++) begin
						exp_q.push_back(ref_result(bl, a, b, l, hist_q.size() - integ_cur,
							integ_cur));
					end
					bl++;
				end
			end
			integ_cnt = 0;
			n_integ++;
		end
	endtask

	task automatic compare_value(input string what, input longint got, input longint exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// a vector offered is held until the handshake seen at the falling edge completes.
	// only a vector that closes an integration may be held off.
	task automatic send_vectors(input int count, input int kind, input logic gaps);
		int   sent;
		logic busy;
		logic closing;
		sent = 0;
		busy = 1'b0;
		while (sent < count) begin
			@(posedge pllclk);
			if (!busy) begin
				if (gaps && !lfsr_bit()) begin
					in_valid <= 1'b0;
				end else begin
					in_valid <= 1'b1;
					in_data <= make_vector(kind);
					busy = 1'b1;
				end
			end
			@(negedge pllclk);
			closing = (integ_cnt == 0) ? (integ_len <= 8'd1) : (integ_cnt + 1 == integ_cur);
			if (in_valid && !closing) begin
				compare_value("in_ready mid-integration", longint'(in_ready), 1);
			end
			if (in_valid && in_ready) begin
				record_vector(in_data);
				sent++;
				busy = 1'b0;
			end
		end
		@(posedge pllclk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || out_valid) begin
			@(posedge pllclk);
		end
		repeat (2) @(posedge pllclk);
	endtask

	always @(negedge pllclk) begin
		ready_bit = stall_mode ? lfsr_bit() : 1'b1;
	end

	always @(posedge pllclk) begin
		out_ready <= ready_bit;
	end

	always @(negedge pllclk) begin
		if (reset) begin
			if (stalled) begin
				compare_value("out_valid while stalled", longint'(out_valid), 1);
				compare_value("out_data while stalled", longint'(out_data), longint'(held));
			end
			if (out_valid && out_ready) begin
				n_out++;
				if (exp_q.size() == 0) begin
					other_count++;
					$display("at %0t an output word arrived with no result expected", $time);
				end else begin
					want = exp_q.pop_front();
					compare_value("baseline", longint'(out_data.baseline),
						longint'(want.baseline));
					compare_value("lag", longint'(out_data.lag), longint'(want.lag));
					compare_value("sum", longint'(out_data.sum), longint'(want.sum));
					compare_value("overflow", longint'(out_data.overflow),
						longint'(want.overflow));
				end
			end
			stalled = out_valid && !out_ready;
			held = out_data;
		end
	end

	initial begin
		while (cycles < timeout_cycles) begin
			@(posedge pllclk);
			cycles++;
		end
		other_count++;
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		integ_len = 8'd4;
		chan_enable = '1;
		out_ready = 1'b1;
		repeat (10) @(posedge pllclk);
		reset <= 1'b1;
		@(posedge pllclk);

		send_vectors(8, 0, 1'b0);
		wait_drain();

		// lag 1 and 2 of each new integration reach back into the previous one.
		integ_len <= 8'd5;
		send_vectors(15, 0, 1'b0);
		wait_drain();

		integ_len <= 8'd4;
		chan_enable <= 4'b1011;
		send_vectors(8, 0, 1'b0);
		wait_drain();
		chan_enable <= '1;

		integ_len <= 8'd16;
		send_vectors(16, 1, 1'b0);
		send_vectors(16, 2, 1'b0);
		send_vectors(16, 0, 1'b0);
		wait_drain();

		stall_mode = 1'b1;
		integ_len <= 8'd3;
		send_vectors(12, 0, 1'b1);
		wait_drain();
		integ_len <= 8'd0;
		send_vectors(3, 0, 1'b1);
		wait_drain();
		stall_mode = 1'b0;

		compare_value("output word count", longint'(n_out),
			longint'(n_integ * `CORR_NUM_CELLS));
		compare_value("integration count", longint'(n_integ), longint'(total_integ));
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
